// ==== compile.f ====
+incdir+include
rtl/udp_pkg.sv
rtl/arp_rx_decode.sv
rtl/udp_link_ctrl.sv
rtl/udp_frame_tx.sv
rtl/udp_sender.sv
testbench/udp_sender_assertions.sv
testbench/udp_sender_tb.sv

// ==== include/udp_defs.svh ====
`ifndef UDP_DEFS_SVH
`define UDP_DEFS_SVH

// Our own station
`define LOCAL_MAC        48'h11_11_11_11_11_11
// 192.168.1.110
`define LOCAL_IP         32'hC0_A8_01_6E
`define LOCAL_PORT       16'h8080

// Peer station
// 192.168.1.105
`define DEST_IP          32'hC0_A8_01_69
`define DEST_PORT        16'h8080

// Settle time before each ARP request and the reply timeout.
// Hardware uses 200 ms at 125 MHz, i.e. 25_000_000
`define ARP_WAIT_CYCLES  200

// EtherType values
`define ETH_TYPE_IPV4    16'h0800
`define ETH_TYPE_ARP     16'h0806

// ARP opcodes
`define ARP_OP_REQUEST   16'h0001
`define ARP_OP_REPLY     16'h0002

// Frame sizes in bytes, without preamble and FCS
`define ARP_FRAME_LEN    42
`define UDP_HDR_LEN      42

// IPv4 header alone, and UDP header alone
`define IP_HDR_LEN       20
`define UDP_BASE_LEN     8

// IPv4 fields
`define IP_TTL           8'd64
`define IP_PROTO_UDP     8'd17

`endif

// ==== rtl/arp_rx_decode.sv ====
`include "udp_defs.svh"

module arp_rx_decode (
    input  logic               rgmii_clk,
    input  logic               arp_rstn,
    input  logic               mac_rx_valid,
    input  udp_pkg::byte_t     mac_rx_data,
    output logic               arp_found,
    output udp_pkg::mac_addr_t peer_mac
);

    localparam udp_pkg::mac_addr_t OWN_MAC  = `LOCAL_MAC;
    localparam udp_pkg::ip_addr_t  OWN_IP   = `LOCAL_IP;
    localparam udp_pkg::ip_addr_t  PEER_IP  = `DEST_IP;
    localparam logic [15:0]        TYPE_ARP = `ETH_TYPE_ARP;
    localparam logic [15:0]        OP_REPLY = `ARP_OP_REPLY;
    localparam udp_pkg::len_t      MIN_LEN  = `ARP_FRAME_LEN;

    udp_pkg::len_t      rx_cnt;
    logic               rx_valid_d;
    logic               dst_local;
    logic               dst_bcast;
    logic               fields_ok;
    logic               byte_ok;
    logic               local_hit;
    logic               frame_end;
    logic               accept;
    udp_pkg::mac_addr_t sender_mac;

    function automatic udp_pkg::byte_t ip_byte(udp_pkg::ip_addr_t ip, logic [1:0] pos);
        return ip[8 * (3 - pos) +: 8];
    endfunction

    assign local_hit = (rx_cnt < 16'd6) &&
                       (mac_rx_data == OWN_MAC[8 * (5 - rx_cnt[2:0]) +: 8]);
    assign frame_end = rx_valid_d && !mac_rx_valid;
    assign accept    = frame_end && (dst_local || dst_bcast) && fields_ok &&
                       (rx_cnt >= MIN_LEN);

    // EtherType, opcode and both protocol addresses
    always_comb begin
        case (rx_cnt)
            16'd12:  byte_ok = (mac_rx_data == TYPE_ARP[15:8]);
            16'd13:  byte_ok = (mac_rx_data == TYPE_ARP[7:0]);
            16'd20:  byte_ok = (mac_rx_data == OP_REPLY[15:8]);
            16'd21:  byte_ok = (mac_rx_data == OP_REPLY[7:0]);
            16'd28, 16'd29, 16'd30, 16'd31:
                byte_ok = (mac_rx_data == ip_byte(PEER_IP, 2'(rx_cnt - 16'd28)));
            16'd38, 16'd39, 16'd40, 16'd41:
                byte_ok = (mac_rx_data == ip_byte(OWN_IP, 2'(rx_cnt - 16'd38)));
            default: byte_ok = 1'b1;
        endcase
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            rx_cnt     <= '0;
            rx_valid_d <= 1'b0;
            dst_local  <= 1'b0;
            dst_bcast  <= 1'b0;
            fields_ok  <= 1'b0;
            arp_found  <= 1'b0;
        end else begin
            rx_valid_d <= mac_rx_valid;
            arp_found  <= accept;
            if (mac_rx_valid) begin
                if (rx_cnt != 16'hFFFF) begin
                    rx_cnt <= rx_cnt + 16'd1;
                end
                if (rx_cnt == 16'd0) begin
                    dst_local <= local_hit;
                    dst_bcast <= (mac_rx_data == 8'hFF);
                    fields_ok <= 1'b1;
                end else begin
                    if (rx_cnt < 16'd6) begin
                        dst_local <= dst_local && local_hit;
                        dst_bcast <= dst_bcast && (mac_rx_data == 8'hFF);
                    end
                    fields_ok <= fields_ok && byte_ok;
                end
            end else begin
                rx_cnt <= '0;
            end
        end
    end

    // Sender hardware address sits at bytes 22..27
    always_ff @(posedge rgmii_clk) begin
        if (mac_rx_valid && (rx_cnt >= 16'd22) && (rx_cnt <= 16'd27)) begin
            sender_mac <= {sender_mac[39:0], mac_rx_data};
        end
        if (accept) begin
            peer_mac <= sender_mac;
        end
    end

endmodule : arp_rx_decode

// ==== rtl/udp_frame_tx.sv ====
`include "udp_defs.svh"

module udp_frame_tx (
    input  logic               rgmii_clk,
    input  logic               arp_rstn,
    input  logic               arp_req,
    input  logic               udp_req,
    input  logic               app_valid,
    input  udp_pkg::byte_t     app_data,
    input  udp_pkg::len_t      app_len,
    input  udp_pkg::mac_addr_t peer_mac,
    output logic               udp_ack,
    output logic               frame_done,
    output logic               mac_tx_valid,
    output udp_pkg::byte_t     mac_tx_data
);

    localparam udp_pkg::mac_addr_t OWN_MAC      = `LOCAL_MAC;
    localparam udp_pkg::ip_addr_t  OWN_IP       = `LOCAL_IP;
    localparam udp_pkg::ip_addr_t  PEER_IP      = `DEST_IP;
    localparam udp_pkg::port_t     SRC_PORT     = `LOCAL_PORT;
    localparam udp_pkg::port_t     DST_PORT     = `DEST_PORT;
    localparam logic [15:0]        TYPE_IPV4    = `ETH_TYPE_IPV4;
    localparam logic [15:0]        TYPE_ARP     = `ETH_TYPE_ARP;
    localparam logic [15:0]        OP_REQUEST   = `ARP_OP_REQUEST;
    localparam logic [15:0]        IP_VER_TOS   = 16'h4500;
    localparam logic [15:0]        IP_TTL_PROTO = {`IP_TTL, `IP_PROTO_UDP};
    localparam udp_pkg::len_t      ARP_LAST     = `ARP_FRAME_LEN - 1;
    localparam udp_pkg::len_t      HDR_LAST     = `UDP_HDR_LEN - 1;

    udp_pkg::tx_phase_t           phase;
    udp_pkg::len_t                byte_cnt;
    udp_pkg::len_t                pay_len;
    udp_pkg::csum_t               ip_csum_q;
    udp_pkg::len_t                ip_len;
    udp_pkg::len_t                udp_len;
    logic [8*`ARP_FRAME_LEN-1:0]  arp_frame;
    logic [8*`UDP_HDR_LEN-1:0]    udp_hdr;
    logic [5:0]                   hdr_pos;
    logic                         send_arp;
    udp_pkg::byte_t               hdr_byte;
    udp_pkg::byte_t               next_byte;

    // Ones' complement sum over the IPv4 header with the checksum field at zero
    function automatic udp_pkg::csum_t ip_csum(udp_pkg::len_t total_len);
        logic [31:0] sum;
        sum = 32'(IP_VER_TOS) + 32'(total_len) + 32'(IP_TTL_PROTO) +
              32'(OWN_IP[31:16]) + 32'(OWN_IP[15:0]) +
              32'(PEER_IP[31:16]) + 32'(PEER_IP[15:0]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        return ~sum[15:0];
    endfunction

    assign ip_len  = pay_len + 16'(`IP_HDR_LEN + `UDP_BASE_LEN);
    assign udp_len = pay_len + 16'(`UDP_BASE_LEN);

    // Broadcast request, Ethernet/IPv4 hardware and protocol types
    assign arp_frame = {48'hFFFF_FFFF_FFFF, OWN_MAC, TYPE_ARP, 16'h0001, TYPE_IPV4,
                        8'd6, 8'd4, OP_REQUEST, OWN_MAC, OWN_IP, 48'h0, PEER_IP};

    assign udp_hdr = {peer_mac, OWN_MAC, TYPE_IPV4,
                      IP_VER_TOS, ip_len, 16'h0000, 16'h0000, IP_TTL_PROTO, ip_csum_q,
                      OWN_IP, PEER_IP,
                      SRC_PORT, DST_PORT, udp_len, 16'h0000};

    assign hdr_pos   = (byte_cnt <= HDR_LAST) ? 6'(byte_cnt) : 6'd0;
    assign send_arp  = (phase == udp_pkg::TX_ARP) || ((phase == udp_pkg::TX_IDLE) && arp_req);
    assign hdr_byte  = send_arp ? arp_frame[8 * (int'(ARP_LAST) - int'(hdr_pos)) +: 8]
                                : udp_hdr[8 * (int'(HDR_LAST) - int'(hdr_pos)) +: 8];
    assign next_byte = (phase == udp_pkg::TX_PAYLOAD) ? app_data : hdr_byte;

    // Last header byte is being loaded
    assign udp_ack = (phase == udp_pkg::TX_HDR) && (byte_cnt == HDR_LAST);

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            phase        <= udp_pkg::TX_IDLE;
            byte_cnt     <= '0;
            mac_tx_valid <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            frame_done <= mac_tx_valid && (phase == udp_pkg::TX_IDLE);
            case (phase)
                udp_pkg::TX_IDLE: begin
                    mac_tx_valid <= arp_req || udp_req;
                    if (arp_req) begin
                        phase    <= udp_pkg::TX_ARP;
                        byte_cnt <= 16'd1;
                    end else if (udp_req) begin
                        phase    <= udp_pkg::TX_HDR;
                        byte_cnt <= 16'd1;
                    end
                end
                udp_pkg::TX_ARP: begin
                    mac_tx_valid <= 1'b1;
                    if (byte_cnt == ARP_LAST) begin
                        phase    <= udp_pkg::TX_IDLE;
                        byte_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
                udp_pkg::TX_HDR: begin
                    mac_tx_valid <= 1'b1;
                    if (byte_cnt == HDR_LAST) begin
                        phase    <= udp_pkg::TX_PAYLOAD;
                        byte_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
                default: begin
                    // Payload follows the source, gaps included
                    mac_tx_valid <= app_valid;
                    if (app_valid) begin
                        if (byte_cnt == pay_len - 16'd1) begin
                            phase    <= udp_pkg::TX_IDLE;
                            byte_cnt <= '0;
                        end else begin
                            byte_cnt <= byte_cnt + 16'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge rgmii_clk) begin
        mac_tx_data <= next_byte;
        if (phase == udp_pkg::TX_IDLE) begin
            pay_len   <= app_len;
            ip_csum_q <= ip_csum(app_len + 16'(`IP_HDR_LEN + `UDP_BASE_LEN));
        end
    end

endmodule : udp_frame_tx

// ==== rtl/udp_link_ctrl.sv ====
`include "udp_defs.svh"

module udp_link_ctrl (
    input  logic           rgmii_clk,
    input  logic           arp_rstn,
    input  logic           trig,
    input  udp_pkg::len_t  index,
    input  logic           tx_valid,
    input  udp_pkg::byte_t tx_data,
    input  udp_pkg::len_t  tx_data_len,
    input  logic           arp_found,
    input  logic           udp_ack,
    output logic           tx_read_en,
    output logic           connected,
    output logic           arp_req,
    output logic           udp_req,
    output logic           app_valid,
    output udp_pkg::byte_t app_data,
    output udp_pkg::len_t  app_len
);

    // Wide enough for the hardware wait and for a byte count
    localparam int WAIT_W = ($clog2(`ARP_WAIT_CYCLES) > 16) ? $clog2(`ARP_WAIT_CYCLES) : 16;
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`ARP_WAIT_CYCLES - 1);

    udp_pkg::link_state_t state;
    logic [WAIT_W-1:0]    wait_cnt;
    udp_pkg::len_t        data_len;
    logic                 wait_done;
    logic                 take_byte;
    logic                 last_byte;

    assign wait_done = (wait_cnt == WAIT_LAST);
    assign take_byte = tx_read_en && tx_valid;
    assign last_byte = (wait_cnt == WAIT_W'(data_len - 16'd1));

    assign arp_req   = (state == udp_pkg::LINK_ARP_REQ);
    assign udp_req   = (state == udp_pkg::LINK_GEN_REQ);
    assign connected = !(state inside {udp_pkg::LINK_SETTLE, udp_pkg::LINK_ARP_REQ,
                                       udp_pkg::LINK_ARP_WAIT});

    // Index goes out first, high byte leading
    assign app_len = data_len + 16'd2;

    always_comb begin
        case (state)
            udp_pkg::LINK_IDX_HI: begin
                app_valid = 1'b1;
                app_data  = index[15:8];
            end
            udp_pkg::LINK_IDX_LO: begin
                app_valid = 1'b1;
                app_data  = index[7:0];
            end
            udp_pkg::LINK_DATA: begin
                app_valid = take_byte;
                app_data  = tx_data;
            end
            default: begin
                app_valid = 1'b0;
                app_data  = tx_data;
            end
        endcase
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            state      <= udp_pkg::LINK_SETTLE;
            wait_cnt   <= '0;
            data_len   <= '0;
            tx_read_en <= 1'b0;
        end else begin
            case (state)
                udp_pkg::LINK_SETTLE: begin
                    if (wait_done) begin
                        wait_cnt <= '0;
                        state    <= udp_pkg::LINK_ARP_REQ;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                udp_pkg::LINK_ARP_REQ: begin
                    state <= udp_pkg::LINK_ARP_WAIT;
                end
                udp_pkg::LINK_ARP_WAIT: begin
                    if (arp_found) begin
                        wait_cnt <= '0;
                        state    <= udp_pkg::LINK_IDLE;
                    end else if (wait_done) begin
                        // No reply, start over with a fresh settle time
                        wait_cnt <= '0;
                        state    <= udp_pkg::LINK_SETTLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                udp_pkg::LINK_IDLE: begin
                    if (trig) begin
                        data_len <= tx_data_len;
                        state    <= udp_pkg::LINK_GEN_REQ;
                    end
                end
                udp_pkg::LINK_GEN_REQ: begin
                    if (udp_ack) begin
                        state <= udp_pkg::LINK_IDX_HI;
                    end
                end
                udp_pkg::LINK_IDX_HI: begin
                    state <= udp_pkg::LINK_IDX_LO;
                end
                udp_pkg::LINK_IDX_LO: begin
                    if (data_len != 16'd0) begin
                        tx_read_en <= 1'b1;
                        wait_cnt   <= '0;
                        state      <= udp_pkg::LINK_DATA;
                    end else begin
                        state <= udp_pkg::LINK_IDLE;
                    end
                end
                udp_pkg::LINK_DATA: begin
                    if (take_byte) begin
                        if (last_byte) begin
                            tx_read_en <= 1'b0;
                            wait_cnt   <= '0;
                            state      <= udp_pkg::LINK_IDLE;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= udp_pkg::LINK_SETTLE;
                end
            endcase
        end
    end

endmodule : udp_link_ctrl

// ==== rtl/udp_pkg.sv ====
package udp_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] csum_t;

    // Link controller states
    typedef enum logic [2:0] {
        LINK_SETTLE,
        LINK_ARP_REQ,
        LINK_ARP_WAIT,
        LINK_IDLE,
        LINK_GEN_REQ,
        LINK_IDX_HI,
        LINK_IDX_LO,
        LINK_DATA
    } link_state_t;

    // Frame builder phases
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_ARP,
        TX_HDR,
        TX_PAYLOAD
    } tx_phase_t;

endpackage : udp_pkg

// ==== rtl/udp_sender.sv ====
module udp_sender (
    input  logic           rgmii_clk,
    input  logic           arp_rstn,
    input  logic           trig,
    input  udp_pkg::len_t  index,
    output logic           tx_read_en,
    input  logic           tx_valid,
    input  udp_pkg::byte_t tx_data,
    input  udp_pkg::len_t  tx_data_len,
    output logic           connected,
    input  logic           mac_rx_valid,
    input  udp_pkg::byte_t mac_rx_data,
    output logic           mac_tx_valid,
    output udp_pkg::byte_t mac_tx_data
);

    logic               arp_found;
    udp_pkg::mac_addr_t peer_mac;
    logic               arp_req;
    logic               udp_req;
    logic               udp_ack;
    logic               app_valid;
    udp_pkg::byte_t     app_data;
    udp_pkg::len_t      app_len;
    logic               frame_done;

    arp_rx_decode u_arp_rx_decode (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .mac_rx_valid(mac_rx_valid),
        .mac_rx_data (mac_rx_data),
        .arp_found   (arp_found),
        .peer_mac    (peer_mac)
    );

    udp_link_ctrl u_udp_link_ctrl (
        .rgmii_clk  (rgmii_clk),
        .arp_rstn   (arp_rstn),
        .trig       (trig),
        .index      (index),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_data_len(tx_data_len),
        .arp_found  (arp_found),
        .udp_ack    (udp_ack),
        .tx_read_en (tx_read_en),
        .connected  (connected),
        .arp_req    (arp_req),
        .udp_req    (udp_req),
        .app_valid  (app_valid),
        .app_data   (app_data),
        .app_len    (app_len)
    );

    udp_frame_tx u_udp_frame_tx (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .arp_req     (arp_req),
        .udp_req     (udp_req),
        .app_valid   (app_valid),
        .app_data    (app_data),
        .app_len     (app_len),
        .peer_mac    (peer_mac),
        .udp_ack     (udp_ack),
        .frame_done  (frame_done),
        .mac_tx_valid(mac_tx_valid),
        .mac_tx_data (mac_tx_data)
    );

endmodule : udp_sender

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module udp_sender_tb -f compile.f

output=$(./obj_dir/Vudp_sender_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== testbench/udp_sender_assertions.sv ====
module udp_sender_assertions (
    input logic rgmii_clk,
    input logic arp_rstn,
    input logic connected,
    input logic tx_read_en,
    input logic mac_tx_valid,
    input logic udp_req,
    input logic udp_ack,
    input logic frame_done
);
    timeunit 1ns;
    timeprecision 100ps;

    // Transmit stream stays quiet while reset is held
    reset_quiet: assert property (@(posedge rgmii_clk) !arp_rstn |-> !mac_tx_valid)
        else $error("mac_tx_valid high during reset");

    // Payload is only pulled once the peer is resolved
    read_needs_link: assert property (
        @(posedge rgmii_clk) disable iff (!arp_rstn)
        tx_read_en |-> connected
    ) else $error("tx_read_en high while not connected");

    // Request stays up until the builder acknowledges it
    req_held: assert property (
        @(posedge rgmii_clk) disable iff (!arp_rstn)
        (udp_req && !udp_ack) |=> udp_req
    ) else $error("udp_req dropped before udp_ack");

    // End of frame marker comes right after the last byte
    done_after_frame: assert property (
        @(posedge rgmii_clk) disable iff (!arp_rstn)
        frame_done |-> $fell(mac_tx_valid)
    ) else $error("frame_done without a frame ending");

endmodule : udp_sender_assertions

// ==== testbench/udp_sender_tb.sv ====
`include "udp_defs.svh"

module udp_sender_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 4 * `ARP_WAIT_CYCLES + 2000;
    localparam udp_pkg::mac_addr_t PEER_MAC = 48'h02_5E_A1_B2_C3_D4;

    logic           rgmii_clk;
    logic           arp_rstn;
    logic           trig;
    udp_pkg::len_t  index;
    logic           tx_read_en;
    logic           tx_valid;
    udp_pkg::byte_t tx_data;
    udp_pkg::len_t  tx_data_len;
    logic           connected;
    logic           mac_rx_valid;
    udp_pkg::byte_t mac_rx_data;
    logic           mac_tx_valid;
    udp_pkg::byte_t mac_tx_data;

    udp_pkg::byte_t cap_q[$];
    udp_pkg::byte_t src_q[$];
    udp_pkg::byte_t exp_q[$];
    int             src_pos;
    int             taken;
    logic           read_seen;
    logic           gaps_on;
    int             errors;
    int             cycles;

    udp_sender dut_i (.*);

    bind udp_sender udp_sender_assertions assertions_i (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .connected   (connected),
        .tx_read_en  (tx_read_en),
        .mac_tx_valid(mac_tx_valid),
        .udp_req     (udp_req),
        .udp_ack     (udp_ack),
        .frame_done  (frame_done)
    );

    initial begin
        rgmii_clk = 1'b0;
        forever #2 rgmii_clk = ~rgmii_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge rgmii_clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without reaching the end", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    // Every transmitted byte in order
    always @(negedge rgmii_clk) begin
        if (mac_tx_valid) begin
            cap_q.push_back(mac_tx_data);
        end
    end

    // Payload source with optional random stalls
    initial begin
        tx_valid = 1'b0;
        tx_data  = '0;
        forever begin
            @(negedge rgmii_clk);
            if (tx_read_en) begin
                read_seen = 1'b1;
            end
            if (tx_read_en && tx_valid) begin
                src_pos++;
                taken++;
            end
            @(posedge rgmii_clk);
            #1;
            tx_data  = (src_pos < src_q.size()) ? src_q[src_pos] : 8'h00;
            tx_valid = gaps_on ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    task automatic next_drive_slot();
        @(posedge rgmii_clk);
        #1;
    endtask

    task automatic check_byte(string name, udp_pkg::byte_t exp, udp_pkg::byte_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_len(string name, udp_pkg::len_t exp, udp_pkg::len_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_mac(string name, udp_pkg::mac_addr_t exp, udp_pkg::mac_addr_t act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %012h, actual %012h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Appends the low n bytes of value with the most significant first
    function automatic void push_field(ref udp_pkg::byte_t q[$], input logic [47:0] value,
                                       input int n);
        for (int i = n - 1; i >= 0; i--) begin
            q.push_back(value[8 * i +: 8]);
        end
    endfunction

    function automatic void build_arp_request();
        exp_q.delete();
        push_field(exp_q, 48'hFFFF_FFFF_FFFF, 6);
        push_field(exp_q, `LOCAL_MAC, 6);
        push_field(exp_q, 16'h0806, 2);
        push_field(exp_q, 48'h0001_0800_0604, 6);
        push_field(exp_q, 16'h0001, 2);
        push_field(exp_q, `LOCAL_MAC, 6);
        push_field(exp_q, `LOCAL_IP, 4);
        push_field(exp_q, 48'h0, 6);
        push_field(exp_q, `DEST_IP, 4);
    endfunction

    function automatic void build_datagram(udp_pkg::mac_addr_t dst, udp_pkg::len_t idx);
        udp_pkg::len_t plen;
        logic [31:0]   sum;
        plen = 16'(src_q.size()) + 16'd2;
        exp_q.delete();
        push_field(exp_q, dst, 6);
        push_field(exp_q, `LOCAL_MAC, 6);
        push_field(exp_q, 16'h0800, 2);
        push_field(exp_q, 16'h4500, 2);
        push_field(exp_q, plen + 16'd28, 2);
        push_field(exp_q, 48'h0, 4);
        push_field(exp_q, 16'h4011, 2);
        push_field(exp_q, 48'h0, 2);
        push_field(exp_q, `LOCAL_IP, 4);
        push_field(exp_q, `DEST_IP, 4);
        push_field(exp_q, `LOCAL_PORT, 2);
        push_field(exp_q, `DEST_PORT, 2);
        push_field(exp_q, plen + 16'd8, 2);
        push_field(exp_q, 48'h0, 2);
        // IPv4 header spans bytes 14 to 33
        sum = 0;
        for (int i = 14; i < 34; i += 2) begin
            sum += {exp_q[i], exp_q[i + 1]};
        end
        while (sum > 32'hFFFF) begin
            sum = sum[15:0] + sum[31:16];
        end
        exp_q[24] = ~sum[15:8];
        exp_q[25] = ~sum[7:0];
        push_field(exp_q, idx, 2);
        foreach (src_q[i]) begin
            exp_q.push_back(src_q[i]);
        end
    endfunction

    task automatic send_arp_reply(udp_pkg::mac_addr_t mac, udp_pkg::ip_addr_t ip);
        udp_pkg::byte_t frame[$];
        push_field(frame, `LOCAL_MAC, 6);
        push_field(frame, mac, 6);
        push_field(frame, 16'h0806, 2);
        push_field(frame, 48'h0001_0800_0604, 6);
        push_field(frame, 16'h0002, 2);
        push_field(frame, mac, 6);
        push_field(frame, ip, 4);
        push_field(frame, `LOCAL_MAC, 6);
        push_field(frame, `LOCAL_IP, 4);
        foreach (frame[i]) begin
            next_drive_slot();
            mac_rx_valid = 1'b1;
            mac_rx_data  = frame[i];
        end
        next_drive_slot();
        mac_rx_valid = 1'b0;
    endtask

    // Waits for n bytes and then a quiet stretch that catches any surplus
    task automatic wait_frame(int n);
        while (cap_q.size() < n) begin
            @(negedge rgmii_clk);
        end
        repeat (8) @(negedge rgmii_clk);
    endtask

    task automatic compare_frame(string name);
        check_len({name, " frame length"}, 16'(exp_q.size()), 16'(cap_q.size()));
        foreach (exp_q[i]) begin
            if (i < cap_q.size()) begin
                check_byte($sformatf("%s byte %0d", name, i), exp_q[i], cap_q[i]);
            end
        end
    endtask

    task automatic run_datagram(string name, udp_pkg::len_t idx, int len, logic gaps,
                                logic extra_trig);
        src_q.delete();
        for (int i = 0; i < len; i++) begin
            src_q.push_back(8'($urandom));
        end
        src_pos   = 0;
        taken     = 0;
        read_seen = 1'b0;
        gaps_on   = gaps;
        cap_q.delete();
        next_drive_slot();
        index       = idx;
        tx_data_len = 16'(len);
        trig        = 1'b1;
        next_drive_slot();
        trig = 1'b0;
        if (extra_trig) begin
            // Lands while the header is still going out
            repeat (20) next_drive_slot();
            trig = 1'b1;
            next_drive_slot();
            trig = 1'b0;
        end
        build_datagram(PEER_MAC, idx);
        wait_frame(exp_q.size());
        compare_frame(name);
        check_mac({name, " destination MAC"}, PEER_MAC,
                  {cap_q[0], cap_q[1], cap_q[2], cap_q[3], cap_q[4], cap_q[5]});
        check_len({name, " bytes accepted"}, 16'(len), 16'(taken));
    endtask

    initial begin
        void'($urandom(32'h8ef2));
        errors       = 0;
        arp_rstn     = 1'b0;
        trig         = 1'b0;
        index        = '0;
        tx_data_len  = '0;
        mac_rx_valid = 1'b0;
        mac_rx_data  = '0;
        src_pos      = 0;
        taken        = 0;
        read_seen    = 1'b0;
        gaps_on      = 1'b0;
        repeat (2) @(posedge rgmii_clk);
        #1;
        arp_rstn = 1'b1;
        @(negedge rgmii_clk);
        check_bit("reset connected", 1'b0, connected);
        check_bit("reset tx_read_en", 1'b0, tx_read_en);
        check_bit("reset mac_tx_valid", 1'b0, mac_tx_valid);
        build_arp_request();
        wait_frame(exp_q.size());
        compare_frame("first ARP request");

        // Reply from the wrong IP must neither resolve the link nor set the peer MAC
        cap_q.delete();
        send_arp_reply(PEER_MAC ^ 48'hFF, `DEST_IP ^ 32'h1);
        wait_frame(exp_q.size());
        compare_frame("retried ARP request");
        check_bit("wrong reply connected", 1'b0, connected);

        send_arp_reply(PEER_MAC, `DEST_IP);
        for (int i = 0; i < 10 && !connected; i++) begin
            @(negedge rgmii_clk);
        end
        if (!connected) begin
            errors++;
            $display("Link did not report connected after a valid ARP reply");
        end

        run_datagram("payload with gaps", 16'h1234, 5, 1'b1, 1'b0);
        run_datagram("index only", 16'h00A5, 0, 1'b0, 1'b0);
        check_bit("index only tx_read_en", 1'b0, read_seen);
        run_datagram("back to back first", 16'hBEEF, 3, 1'b0, 1'b1);
        run_datagram("back to back second", 16'hC001, 2, 1'b1, 1'b1);

        $display("Run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : udp_sender_tb
